/* src/robotCmdPkg.sv */
package robotCmdPkg;

    // Motion commands on the 3-bit select input
    typedef enum logic [2:0] {
        Stop      = 3'b000,               // Both wheels idle
        Left      = 3'b001,               // Spin left
        Right     = 3'b010,               // Spin right
        FwdSlow   = 3'b011,               // Forward, 0.05
        FwdMedium = 3'b100,               // Forward, 0.25
        FwdFast   = 3'b101                // Forward, 0.5
    } cmdCode_t;

    localparam int MaxMsgLen = 27;        // Longest text, the turns
    typedef logic [4:0] msgIndex_t;       // Character position in a text

    // Text lengths in bytes, newline included
    localparam logic [7:0] LenStop      = 8'd20;
    localparam logic [7:0] LenLeft      = 8'd27;
    localparam logic [7:0] LenRight     = 8'd27;
    localparam logic [7:0] LenFwdSlow   = 8'd26;
    localparam logic [7:0] LenFwdMedium = 8'd26;
    localparam logic [7:0] LenFwdFast   = 8'd24;

    // ASCII characters of the JSON texts
    localparam logic [7:0] ChBraceOpen  = 8'h7B; // {
    localparam logic [7:0] ChBraceClose = 8'h7D; // }
    localparam logic [7:0] ChQuote      = 8'h22; // "
    localparam logic [7:0] ChColon      = 8'h3A; // :
    localparam logic [7:0] ChComma      = 8'h2C; // ,
    localparam logic [7:0] ChMinus      = 8'h2D; // -
    localparam logic [7:0] ChDot        = 8'h2E; // .
    localparam logic [7:0] ChZero       = 8'h30; // 0
    localparam logic [7:0] ChOne        = 8'h31; // 1
    localparam logic [7:0] ChTwo        = 8'h32; // 2
    localparam logic [7:0] ChFive       = 8'h35; // 5
    localparam logic [7:0] ChT          = 8'h54; // Throttle key
    localparam logic [7:0] ChL          = 8'h4C; // Left wheel key
    localparam logic [7:0] ChR          = 8'h52; // Right wheel key
    localparam logic [7:0] ChNewline    = 8'h0A; // Message terminator
    localparam logic [7:0] ChNul        = 8'h00; // Pad past the end

endpackage

/* src/uartPkg.sv */
package uartPkg;

    // Parity bit setting of the serial frame
    typedef enum logic [1:0] {
        ParityNone = 2'b00,               // No parity bit in the frame
        ParityEven = 2'b01,               // Total ones count even
        ParityOdd  = 2'b10                // Total ones count odd
    } parityMode_t;

    // Frame layout, LSB first on the line
    localparam int DataBits  = 8;         // Payload width
    localparam int StartBits = 1;         // Low level
    localparam int StopBits  = 1;         // High level

endpackage

/* src/commandRom.sv */
`timescale 1ns/1ps

module commandRom import robotCmdPkg::*; (
    input  cmdCode_t   cmd,               // Command latched for this message
    input  msgIndex_t  index,             // Character position, 0 is the brace
    output logic [7:0] msgLength,         // Bytes in the selected text
    output logic [7:0] charByte           // Character at index
);

    localparam int TextBits = 8 * MaxMsgLen; // Flat text, left justified

    logic [8*11-1:0]     headText;        // {"T":1,"L":
    logic [8*5-1:0]      midText;         // ,"R":
    logic [8*2-1:0]      tailText;        // }\n
    logic [TextBits-1:0] textFlat;        // Selected text, first char on top

    // Pieces shared by every text
    assign headText = {ChBraceOpen,
                       ChQuote, ChT, ChQuote, ChColon, ChOne,   // Throttle always 1
                       ChComma,
                       ChQuote, ChL, ChQuote, ChColon};
    assign midText  = {ChComma, ChQuote, ChR, ChQuote, ChColon};
    assign tailText = {ChBraceClose, ChNewline};

    // Wheel speeds differ per command, short texts padded at the bottom
    always_comb begin
        case (cmd)
            Left: begin
                textFlat  = {headText,
                             ChMinus, ChZero, ChDot, ChTwo, ChZero, // -0.20
                             midText,
                             ChZero, ChDot, ChTwo, ChZero,          // 0.20
                             tailText};
                msgLength = LenLeft;
            end
            Right: begin
                textFlat  = {headText,
                             ChZero, ChDot, ChTwo, ChZero,          // 0.20
                             midText,
                             ChMinus, ChZero, ChDot, ChTwo, ChZero, // -0.20
                             tailText};
                msgLength = LenRight;
            end
            FwdSlow: begin
                textFlat  = {headText,
                             ChZero, ChDot, ChZero, ChFive,         // 0.05
                             midText,
                             ChZero, ChDot, ChZero, ChFive,         // 0.05
                             tailText,
                             ChNul};
                msgLength = LenFwdSlow;
            end
            FwdMedium: begin
                textFlat  = {headText,
                             ChZero, ChDot, ChTwo, ChFive,          // 0.25
                             midText,
                             ChZero, ChDot, ChTwo, ChFive,          // 0.25
                             tailText,
                             ChNul};
                msgLength = LenFwdMedium;
            end
            FwdFast: begin
                textFlat  = {headText,
                             ChZero, ChDot, ChFive,                 // 0.5
                             midText,
                             ChZero, ChDot, ChFive,                 // 0.5
                             tailText,
                             {3{ChNul}}};
                msgLength = LenFwdFast;
            end
            default: begin                // Stop, and the spare codes 110/111
                textFlat  = {headText,
                             ChZero,                                // 0
                             midText,
                             ChZero,                                // 0
                             tailText,
                             {7{ChNul}}};
                msgLength = LenStop;
            end
        endcase
    end

    // Index 0 sits in the top byte
    always_comb begin
        if (int'(index) < MaxMsgLen) begin
            charByte = textFlat[TextBits - 8 - 8 * int'(index) +: 8];
        end else begin
            charByte = ChNul;             // Past the longest text
        end
    end

endmodule

/* src/messageSequencer.sv */
`timescale 1ns/1ps

module messageSequencer import robotCmdPkg::*; #(
    parameter int GapCycles = 0           // Idle cycles before each byte
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [2:0] stateControl,      // Raw command select
    input  logic [7:0] msgLength,         // From the command table
    input  logic [7:0] charByte,          // From the command table
    input  logic       txReady,           // Transmitter idle level
    output cmdCode_t   latchedCmd,        // Held for a whole message
    output msgIndex_t  charIndex,         // Current character
    output logic [7:0] txByte,            // Byte offered to the transmitter
    output logic       byteStrobe,        // One cycle, only with txReady
    output logic       messageDone        // One cycle after the last frame
);

    localparam int GapW = (GapCycles > 1) ? $clog2(GapCycles) : 1;

    typedef enum logic [1:0] {
        SeqLoad,                          // Sample command, rewind index
        SeqGap,                           // Count idle cycles
        SeqSend,                          // Wait for txReady, strobe
        SeqFinish                         // Wait for the last frame to drain
    } seqState_t;

    localparam seqState_t NextByteState = (GapCycles == 0) ? SeqSend : SeqGap; // Gap skipped at zero

    seqState_t       state;
    logic [GapW-1:0] gapCount;
    logic            gapEnd;
    logic            lastChar;

    assign gapEnd   = (gapCount == GapW'(GapCycles - 1));
    assign lastChar = (8'(charIndex) == msgLength - 8'd1);

    assign txByte      = charByte;                      // Held with the index
    assign byteStrobe  = (state == SeqSend) && txReady;
    assign messageDone = (state == SeqFinish) && txReady;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= SeqLoad;
            latchedCmd <= Stop;
            charIndex  <= '0;
            gapCount   <= '0;
        end else begin
            case (state)
                SeqLoad: begin
                    latchedCmd <= cmdCode_t'(stateControl); // Once per message
                    charIndex  <= '0;
                    gapCount   <= '0;
                    state      <= NextByteState;
                end
                SeqGap: begin
                    if (gapEnd) begin
                        state <= SeqSend;
                    end else begin
                        gapCount <= gapCount + 1'b1;
                    end
                end
                SeqSend: begin
                    if (txReady) begin                      // Byte taken this edge
                        gapCount <= '0;
                        if (lastChar) begin
                            state <= SeqFinish;
                        end else begin
                            charIndex <= charIndex + 1'b1;
                            state     <= NextByteState;
                        end
                    end
                end
                SeqFinish: begin
                    if (txReady) begin                      // Newline frame out
                        state <= SeqLoad;
                    end
                end
                default: state <= SeqLoad;
            endcase
        end
    end

endmodule

/* src/uartTx.sv */
`timescale 1ns/1ps

module uartTx import uartPkg::*; #(
    parameter int          ClksPerBit = 434,        // 115200 baud at 50 MHz
    parameter parityMode_t Parity     = ParityNone
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [DataBits-1:0] txByte,             // Sampled on the strobe
    input  logic                byteStrobe,
    output logic                txLine,             // Idle high
    output logic                txReady             // High while idle
);

    localparam int ParityBits = (Parity == ParityNone) ? 0 : 1;
    localparam int FrameBits  = StartBits + DataBits + ParityBits + StopBits;
    localparam int TimerW     = $clog2(ClksPerBit + 1);
    localparam int CountW     = $clog2(FrameBits);
    localparam int ShiftW     = DataBits + 1 + StopBits; // Data, parity slot, stop

    logic [TimerW-1:0] bitTimer;          // Cycles within one bit
    logic [CountW-1:0] bitCount;          // Bit currently on the line
    logic [ShiftW-1:0] shiftReg;          // Bits still to send after start
    logic              parityBit;
    logic              busy;
    logic              accept;
    logic              bitEnd;            // Last cycle of a bit
    logic              frameEnd;          // Last bit of the frame

    assign accept   = byteStrobe && !busy;
    assign txReady  = !busy;
    assign bitEnd   = (bitTimer == TimerW'(ClksPerBit - 1));
    assign frameEnd = (bitCount == CountW'(FrameBits - 1));

    // Parity from the byte being accepted
    always_comb begin
        case (Parity)
            ParityEven: parityBit = ^txByte;
            ParityOdd:  parityBit = ~^txByte;
            default:    parityBit = 1'b1;   // Slot becomes the stop level
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            txLine   <= 1'b1;
            bitTimer <= '0;
            bitCount <= '0;
        end else if (accept) begin
            busy     <= 1'b1;
            txLine   <= 1'b0;                           // Start bit next cycle
            bitTimer <= '0;
            bitCount <= '0;
        end else if (busy) begin
            if (bitEnd) begin
                bitTimer <= '0;
                if (frameEnd) begin
                    busy   <= 1'b0;                     // Ready after the stop bit
                    txLine <= 1'b1;
                end else begin
                    bitCount <= bitCount + 1'b1;
                    txLine   <= shiftReg[0];            // LSB first
                end
            end else begin
                bitTimer <= bitTimer + 1'b1;
            end
        end
    end

    // Frame payload, ones shifted in from the top
    always_ff @(posedge clk) begin
        if (accept) begin
            shiftReg <= {{StopBits{1'b1}}, parityBit, txByte};
        end else if (busy && bitEnd && !frameEnd) begin
            shiftReg <= {1'b1, shiftReg[ShiftW-1:1]};
        end
    end

endmodule

/* src/jsonUartTop.sv */
`timescale 1ns/1ps

module jsonUartTop import robotCmdPkg::*, uartPkg::*; #(
    parameter int          ClksPerBit = 434,        // Bit time in clocks
    parameter parityMode_t Parity     = ParityNone,
    parameter int          GapCycles  = 0           // Idle cycles per byte
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [2:0] stateControl,                // Motion command select
    output logic       txLine,                      // Serial output
    output logic       messageDone                  // End of each message
);

    cmdCode_t   latchedCmd;               // Command of the running message
    msgIndex_t  charIndex;
    logic [7:0] msgLength;
    logic [7:0] charByte;
    logic [7:0] txByte;
    logic       byteStrobe;
    logic       txReady;

    messageSequencer #(
        .GapCycles    (GapCycles)
    ) uSequencer (
        .clk          (clk),
        .rst          (rst),
        .stateControl (stateControl),
        .msgLength    (msgLength),
        .charByte     (charByte),
        .txReady      (txReady),
        .latchedCmd   (latchedCmd),
        .charIndex    (charIndex),
        .txByte       (txByte),
        .byteStrobe   (byteStrobe),
        .messageDone  (messageDone)
    );

    // JSON text table, combinational
    commandRom uRom (
        .cmd          (latchedCmd),
        .index        (charIndex),
        .msgLength    (msgLength),
        .charByte     (charByte)
    );

    uartTx #(
        .ClksPerBit   (ClksPerBit),
        .Parity       (Parity)
    ) uTx (
        .clk          (clk),
        .rst          (rst),
        .txByte       (txByte),
        .byteStrobe   (byteStrobe),
        .txLine       (txLine),
        .txReady      (txReady)
    );

endmodule

/* dv/jsonUart_assertions.sv */
`timescale 1ns/1ps

module jsonUartAssertions (
    input logic clk,
    input logic rst,
    input logic byteStrobe,
    input logic txReady,
    input logic messageDone,
    input logic txLine
);

    int failCount = 0;                    // Failed assertions so far

    // Strobe only while the transmitter is idle, taken on that edge
    strobeAccepted: assert property (@(posedge clk) disable iff (rst)
        byteStrobe |-> txReady ##1 !txReady)
    else begin
        failCount++;
        $error("byteStrobe came while txReady was low or the byte was not taken");
    end

    // Done is a single cycle pulse
    doneOneCycle: assert property (@(posedge clk) disable iff (rst)
        messageDone |=> !messageDone)
    else begin
        failCount++;
        $error("messageDone stayed high for more than one cycle");
    end

    // Idle line level
    lineIdleHigh: assert property (@(posedge clk) disable iff (rst)
        txReady |-> txLine)
    else begin
        failCount++;
        $error("txLine was low while txReady was high");
    end

endmodule

bind jsonUartTop jsonUartAssertions uAssertions (
    .clk         (clk),
    .rst         (rst),
    .byteStrobe  (byteStrobe),
    .txReady     (txReady),
    .messageDone (messageDone),
    .txLine      (txLine)
);

/* dv/tbJsonUart.sv */
`timescale 1ns/1ps

module tbJsonUart import robotCmdPkg::*, uartPkg::*; ();

    localparam int          ClksPerBit    = 8;
    localparam parityMode_t TbParity      = ParityEven;
    localparam int          GapCycles     = 3;
    localparam int          MsgCount      = 16;          // Messages checked per run
    localparam int          ChangeCount   = MsgCount - 1;
    localparam int          DriveDelay    = 10;          // ns after the rising edge
    localparam int          TimeoutCycles = 60000;       // 16 x 27 x (88 + gap), plus margin

    logic       clk;
    logic       rst;
    logic [2:0] stateControl;
    logic       txLine;
    logic       messageDone;

    logic [15:0] lfsrState = 16'd29;      // Seed
    logic [7:0]  rxQ[$];                  // Bytes from the line model
    logic [7:0]  expQ[$];                 // Bytes the reference predicts
    int          lenQ[$];                 // Length of each started message
    logic        loadNext;
    logic        rxBusy;
    logic [7:0]  codesSeen = '0;          // One bit per latched code
    int          startCount = 0;
    int          doneCount  = 0;
    int          msgBytes   = 0;          // Bytes since the last done pulse
    int          doneBytes  = 0;
    int          byteCount  = 0;
    int          cycleCount = 0;
    int          errorCount = 0;

    jsonUartTop #(
        .ClksPerBit   (ClksPerBit),
        .Parity       (TbParity),
        .GapCycles    (GapCycles)
    ) u_dut (
        .clk          (clk),
        .rst          (rst),
        .stateControl (stateControl),
        .txLine       (txLine),
        .messageDone  (messageDone)
    );

    // JSON text for a command, spare codes give the stop text
    function automatic string expectedMessage(input logic [2:0] code);
        case (code)
            Left:      return "{\"T\":1,\"L\":-0.20,\"R\":0.20}\n";
            Right:     return "{\"T\":1,\"L\":0.20,\"R\":-0.20}\n";
            FwdSlow:   return "{\"T\":1,\"L\":0.05,\"R\":0.05}\n";
            FwdMedium: return "{\"T\":1,\"L\":0.25,\"R\":0.25}\n";
            FwdFast:   return "{\"T\":1,\"L\":0.5,\"R\":0.5}\n";
            default:   return "{\"T\":1,\"L\":0,\"R\":0}\n";
        endcase
    endfunction

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic int takeBits(input int count);
        logic outBit;
        int   value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            outBit    = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (outBit) begin
                lfsrState = lfsrState ^ 16'hB400;
            end
            value = (value << 1) | int'(outBit);
        end
        return value;
    endfunction

    task automatic reportFailure(input string what);
        $display("%s", what);
        errorCount++;
        $display("Checks failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;           // 100 ns period
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            reportFailure($sformatf("Timeout: run did not finish in %0d cycles",
                                    TimeoutCycles));
        end
    end

    // Bound checker on the line and the strobes
    always @(negedge clk) begin
        assert (u_dut.uAssertions.failCount == 0)
        else reportFailure("A concurrent assertion on the line or the strobes failed");
    end

    // Command changes at random times inside a running message
    initial begin : driveCommands
        int delay;
        int code;
        wait (rst == 1'b0);
        for (int k = 0; k < ChangeCount; k++) begin
            while (startCount <= k) @(posedge clk);
            delay = takeBits(10);         // At most 1023, below the shortest message
            repeat (delay + 1) @(posedge clk);
            if (k < 8) begin
                code = k;                 // Sweep every code once
            end else begin
                code = takeBits(3);
            end
            #DriveDelay stateControl = code[2:0];
        end
    end

    // Message start follows reset and each done pulse
    always @(negedge clk) begin : trackMessages
        string text;
        if (rst) begin
            loadNext = 1'b1;
        end else begin
            if (loadNext) begin           // Sequencer latches on the next edge
                text = expectedMessage(stateControl);
                for (int i = 0; i < text.len(); i++) begin
                    expQ.push_back(text[i]);
                end
                lenQ.push_back(text.len());
                codesSeen[stateControl] = 1'b1;
                startCount++;
                loadNext = 1'b0;
            end
            if (messageDone) begin
                assert (lenQ.size() > 0)
                else reportFailure("messageDone pulsed with no message started");
                assert (msgBytes == lenQ[0])
                else reportFailure($sformatf(
                    "ERROR messageDone byte count: got 0x%h, expected 0x%h",
                    msgBytes, lenQ[0]));
                assert (!rxBusy && txLine === 1'b1)
                else reportFailure("messageDone pulsed while a frame was on the line");
                doneBytes += lenQ.pop_front();
                msgBytes = 0;
                doneCount++;
                loadNext = 1'b1;
            end
        end
    end

    // Line model, samples each bit in its middle
    initial begin : receiveFrames
        logic [7:0] data;
        logic       parityBit;
        rxBusy = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && txLine === 1'b0) begin  // Start edge
                rxBusy = 1'b1;
                repeat (ClksPerBit / 2) @(negedge clk);
                assert (txLine === 1'b0)
                else reportFailure($sformatf(
                    "ERROR txLine start bit: got 0x%h, expected 0x0", txLine));
                for (int b = 0; b < DataBits; b++) begin
                    repeat (ClksPerBit) @(negedge clk);
                    data[b] = txLine;             // LSB first
                end
                if (TbParity != ParityNone) begin
                    repeat (ClksPerBit) @(negedge clk);
                    parityBit = txLine;
                    assert ((^{data, parityBit}) == (TbParity == ParityOdd))
                    else reportFailure($sformatf(
                        "ERROR txLine parity bit: got 0x%h for data 0x%h",
                        parityBit, data));
                end
                repeat (ClksPerBit) @(negedge clk);
                assert (txLine === 1'b1)
                else reportFailure($sformatf(
                    "ERROR txLine stop bit: got 0x%h, expected 0x1", txLine));
                rxQ.push_back(data);
                msgBytes++;
                rxBusy = 1'b0;
            end
        end
    end

    // Received bytes against the reference
    initial begin : compareBytes
        logic [7:0] got;
        logic [7:0] want;
        forever begin
            @(negedge clk);
            while (rxQ.size() > 0) begin
                got = rxQ.pop_front();
                assert (expQ.size() > 0)
                else reportFailure("A byte arrived that no message predicts");
                want = expQ.pop_front();
                assert (got == want)
                else reportFailure($sformatf("ERROR txLine byte %0d: got 0x%h, expected 0x%h",
                                             byteCount, got, want));
                byteCount++;
            end
        end
    end

    initial begin
        rst          = 1'b1;
        stateControl = 3'b100;            // Medium for the first message
        repeat (3) @(posedge clk);
        #DriveDelay rst = 1'b0;
        repeat (GapCycles + 1) begin      // Idle until the first strobe
            @(negedge clk);
            assert (txLine === 1'b1 && messageDone === 1'b0)
            else reportFailure($sformatf("ERROR txLine/messageDone after reset: got 0x%h/0x%h",
                                         txLine, messageDone));
        end
        wait (doneCount == MsgCount);
        assert (byteCount == doneBytes)
        else reportFailure($sformatf("ERROR byteCount: got 0x%h, expected 0x%h",
                                     byteCount, doneBytes));
        assert (codesSeen == 8'hFF)
        else reportFailure($sformatf("ERROR codesSeen: got 0x%h, expected 0xff", codesSeen));
        if (errorCount == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "Run ended with errors");
        end
    end

endmodule

/* list.f */
src/robotCmdPkg.sv
src/uartPkg.sv
src/commandRom.sv
src/messageSequencer.sv
src/uartTx.sv
src/jsonUartTop.sv
dv/jsonUart_assertions.sv
dv/tbJsonUart.sv

/* Bender.yml */
package:
  name: json_uart

sources:
  - src/robotCmdPkg.sv
  - src/uartPkg.sv
  - src/commandRom.sv
  - src/messageSequencer.sv
  - src/uartTx.sv
  - src/jsonUartTop.sv
  - target: simulation
    files:
      - dv/jsonUart_assertions.sv
      - dv/tbJsonUart.sv
